// File: include/thor_cfg.svh
// Thor integer core configuration
// Widths and counts for data words, the register file, instruction fields
// and immediates

`ifndef THOR_CFG_SVH
`define THOR_CFG_SVH

// Data path
`define THOR_VALUE_W 64

// Register file size and register-number width
`define THOR_NREGS 64
`define THOR_REG_AW 6

// Instruction word
`define THOR_INSN_W 32

// Signed immediate field of the register-immediate format
`define THOR_IMM_W 13

// Shift amount taken from the low bits of the second operand
`define THOR_SHAMT_W 6

`endif

// File: logic/thor_pkg.sv
// Thor integer core types
// Data, register-number and instruction types, opcode and function
// encodings, and the decoded-instruction struct passed between stages

`include "thor_cfg.svh"

package thor_pkg;

	typedef logic [`THOR_VALUE_W-1:0] thor_value_t;
	typedef logic [`THOR_REG_AW-1:0] thor_regno_t;
	typedef logic [`THOR_INSN_W-1:0] thor_insn_t;

	// ========================================================================
	// Primary opcodes, instruction bits 6..0
	// ========================================================================
	typedef enum logic [6:0] {
		OP_R2    = 7'h02,
		OP_ADDI  = 7'h04,
		OP_SUBFI = 7'h05,
		OP_ANDI  = 7'h08,
		OP_ORI   = 7'h09,
		OP_XORI  = 7'h0A,
		OP_CMPI  = 7'h0B,
		OP_CMPUI = 7'h0C,
		OP_SLTI  = 7'h0D,
		OP_SLTUI = 7'h0E,
		OP_SEQI  = 7'h0F
	} thor_op_e;

	// ========================================================================
	// R2 functions, instruction bits 31..25
	// ========================================================================
	typedef enum logic [6:0] {
		F_ADD  = 7'h04,
		F_SUB  = 7'h05,
		F_AND  = 7'h08,
		F_OR   = 7'h09,
		F_XOR  = 7'h0A,
		F_CMP  = 7'h0B,
		F_CMPU = 7'h0C,
		F_SLL  = 7'h10,
		F_SRL  = 7'h11,
		F_SRA  = 7'h12
	} thor_func_e;

	// Decoded instruction, carried from decode into execute
	typedef struct packed {
		thor_op_e    op;
		thor_func_e  func;
		thor_regno_t ra;
		thor_regno_t rb;
		thor_regno_t rt;
		// Sign extended to the full data width
		thor_value_t imm;
		logic        use_imm;
		logic        rfwr;
	} thor_deco_t;

endpackage

// File: logic/thor_fwd_if.sv
// Result forwarding bundle
// Execute and writeback results returned to the register file, used for
// operand bypass and, from writeback, as the register write port

interface thor_fwd_if
	import thor_pkg::*;
();

	// Execute stage result, valid in the same cycle it is computed
	logic        x_wr;
	thor_regno_t x_rt;
	thor_value_t x_res;

	// Writeback stage result
	logic        w_wr;
	thor_regno_t w_rt;
	thor_value_t w_res;

	modport core (
		output x_wr, x_rt, x_res,
		output w_wr, w_rt, w_res
	);

	modport rf (
		input x_wr, x_rt, x_res,
		input w_wr, w_rt, w_res
	);

endinterface

// File: logic/thor_decoder.sv
// Thor instruction decoder
// Splits a 32-bit instruction word into register numbers, opcode, function
// and a sign-extended immediate, and flags register writes

`include "thor_cfg.svh"

module thor_decoder
	import thor_pkg::*;
(
	input  thor_insn_t insn_i,
	output thor_deco_t deco_o
);

	thor_op_e                op;
	thor_func_e              func;
	logic [`THOR_IMM_W-1:0]  imm_f;
	thor_regno_t             rt;
	logic                    known;

	// Fixed field positions
	assign op    = thor_op_e'(insn_i[6:0]);
	assign func  = thor_func_e'(insn_i[31:25]);
	assign imm_f = insn_i[31:19];
	assign rt    = insn_i[12:7];

	// Only known opcode and function pairs may write a register
	always_comb begin
		known = 1'b0;
		case (op)
			OP_R2: begin
				case (func)
					F_ADD, F_SUB, F_AND, F_OR, F_XOR,
					F_SLL, F_SRL, F_SRA, F_CMP, F_CMPU:
						known = 1'b1;
					default:
						known = 1'b0;
				endcase
			end
			OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI,
			OP_CMPI, OP_CMPUI, OP_SLTI, OP_SLTUI, OP_SEQI:
				known = 1'b1;
			default:
				known = 1'b0;
		endcase
	end

	always_comb begin
		deco_o.op   = op;
		deco_o.func = func;
		deco_o.rt   = rt;
		deco_o.ra   = insn_i[18:13];
		// Rb overlaps the low immediate bits, harmless for immediate forms
		deco_o.rb   = insn_i[24:19];
		deco_o.imm  = {{(`THOR_VALUE_W-`THOR_IMM_W){imm_f[`THOR_IMM_W-1]}}, imm_f};

		// Every known opcode other than R2 takes the immediate
		deco_o.use_imm = known && (op != OP_R2);

		// Register 0 is never written
		deco_o.rfwr = known && (rt != '0);
	end

endmodule

// File: logic/thor_regfile.sv
// Thor register file
// 64 general registers with two combinational read ports and one write
// port from writeback; register 0 reads zero and both read ports bypass
// pending results from execute and writeback

`include "thor_cfg.svh"

module thor_regfile
	import thor_pkg::*;
(
	input  logic        clk_g,
	input  thor_regno_t ra_i,
	input  thor_regno_t rb_i,
	thor_fwd_if.rf      fwd,
	output thor_value_t a_o,
	output thor_value_t b_o
);

	thor_value_t regs [`THOR_NREGS];

	// Read one port: zero register, then execute, then writeback, then storage
	function automatic thor_value_t fn_read(
		input thor_regno_t rn,
		input thor_value_t stored,
		input logic        x_wr,
		input thor_regno_t x_rt,
		input thor_value_t x_res,
		input logic        w_wr,
		input thor_regno_t w_rt,
		input thor_value_t w_res
	);
		if (rn == '0)
			return '0;
		else if (x_wr && rn == x_rt)
			return x_res;
		else if (w_wr && rn == w_rt)
			return w_res;
		else
			return stored;
	endfunction

	// Write port, fed from the writeback stage
	always_ff @(posedge clk_g) begin
		if (fwd.w_wr)
			regs[fwd.w_rt] <= fwd.w_res;
	end

	always_comb begin
		a_o = fn_read(ra_i, regs[ra_i], fwd.x_wr, fwd.x_rt, fwd.x_res,
			fwd.w_wr, fwd.w_rt, fwd.w_res);
	end

	always_comb begin
		b_o = fn_read(rb_i, regs[rb_i], fwd.x_wr, fwd.x_rt, fwd.x_res,
			fwd.w_wr, fwd.w_rt, fwd.w_res);
	end

endmodule

// File: logic/thor_alu.sv
// Thor execute-stage ALU
// Combinational add, subtract, logic, shift, compare and set operations,
// selected by opcode and R2 function

`include "thor_cfg.svh"

module thor_alu
	import thor_pkg::*;
(
	input  thor_deco_t  deco_i,
	input  thor_value_t a_i,
	input  thor_value_t b_i,
	output thor_value_t res_o
);

	thor_value_t              op2;
	logic [`THOR_SHAMT_W-1:0] shamt;

	// Three-way compare: all ones below, zero equal, one above
	function automatic thor_value_t fn_cmp(
		input thor_value_t a,
		input thor_value_t b,
		input logic        sgn
	);
		logic lt;
		lt = sgn ? ($signed(a) < $signed(b)) : (a < b);
		if (lt)
			return '1;
		else if (a == b)
			return '0;
		else
			return thor_value_t'(1);
	endfunction

	assign op2   = deco_i.use_imm ? deco_i.imm : b_i;
	assign shamt = op2[`THOR_SHAMT_W-1:0];

	// ========================================================================
	// Result select
	// ========================================================================
	always_comb begin
		res_o = '0;
		case (deco_i.op)
			OP_R2: begin
				case (deco_i.func)
					F_ADD:   res_o = a_i + op2;
					F_SUB:   res_o = a_i - op2;
					F_AND:   res_o = a_i & op2;
					F_OR:    res_o = a_i | op2;
					F_XOR:   res_o = a_i ^ op2;
					F_SLL:   res_o = a_i << shamt;
					F_SRL:   res_o = a_i >> shamt;
					F_SRA:   res_o = $signed(a_i) >>> shamt;
					F_CMP:   res_o = fn_cmp(a_i, op2, 1'b1);
					F_CMPU:  res_o = fn_cmp(a_i, op2, 1'b0);
					default: res_o = '0;
				endcase
			end
			OP_ADDI:  res_o = a_i + op2;
			// Reverse subtract, immediate minus register
			OP_SUBFI: res_o = op2 - a_i;
			OP_ANDI:  res_o = a_i & op2;
			OP_ORI:   res_o = a_i | op2;
			OP_XORI:  res_o = a_i ^ op2;
			OP_CMPI:  res_o = fn_cmp(a_i, op2, 1'b1);
			OP_CMPUI: res_o = fn_cmp(a_i, op2, 1'b0);
			OP_SLTI:  res_o = thor_value_t'($signed(a_i) < $signed(op2));
			OP_SLTUI: res_o = thor_value_t'(a_i < op2);
			OP_SEQI:  res_o = thor_value_t'(a_i == op2);
			default:  res_o = '0;
		endcase
	end

endmodule

// File: logic/thor_core.sv
// Thor integer pipeline, top level
// Decode and register read, execute and writeback stages with result
// bypass; takes one instruction per strobe and reports each register write

module thor_core
	import thor_pkg::*;
(
	input  logic        clk_g,
	input  logic        rst_i,
	input  logic        insn_valid_i,
	input  thor_insn_t  insn_i,
	output logic        wb_valid_o,
	output thor_regno_t wb_rt_o,
	output thor_value_t wb_res_o
);

	// Decode stage
	logic        d_valid;
	thor_insn_t  d_insn;
	thor_deco_t  d_deco;
	thor_value_t rf_a;
	thor_value_t rf_b;

	// Execute stage
	logic        x_valid;
	thor_deco_t  x_deco;
	thor_value_t x_a;
	thor_value_t x_b;
	thor_value_t x_res;

	// Writeback stage
	logic        w_valid;
	thor_regno_t w_rt;
	thor_value_t w_res;

	thor_fwd_if fwd0 ();

	// ========================================================================
	// Stage valid bits
	// ========================================================================
	// No stalls, every stage advances each cycle
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			d_valid <= 1'b0;
			x_valid <= 1'b0;
			w_valid <= 1'b0;
		end else begin
			d_valid <= insn_valid_i;
			x_valid <= d_valid;
			// Only writing instructions reach writeback
			w_valid <= x_valid && x_deco.rfwr;
		end
	end

	// ========================================================================
	// Stage payload
	// ========================================================================
	always_ff @(posedge clk_g) begin
		d_insn <= insn_i;
		x_deco <= d_deco;
		x_a    <= rf_a;
		x_b    <= rf_b;
		w_rt   <= x_deco.rt;
		w_res  <= x_res;
	end

	// Decode and register read
	thor_decoder u_decoder (
		.insn_i (d_insn),
		.deco_o (d_deco)
	);

	thor_regfile u_regfile (
		.clk_g (clk_g),
		.ra_i  (d_deco.ra),
		.rb_i  (d_deco.rb),
		.fwd   (fwd0.rf),
		.a_o   (rf_a),
		.b_o   (rf_b)
	);

	// Execute
	thor_alu u_alu (
		.deco_i (x_deco),
		.a_i    (x_a),
		.b_i    (x_b),
		.res_o  (x_res)
	);

	// Results back to the register file
	assign fwd0.x_wr  = x_valid && x_deco.rfwr;
	assign fwd0.x_rt  = x_deco.rt;
	assign fwd0.x_res = x_res;
	assign fwd0.w_wr  = w_valid;
	assign fwd0.w_rt  = w_rt;
	assign fwd0.w_res = w_res;

	// Writeback report
	assign wb_valid_o = w_valid;
	assign wb_rt_o    = w_rt;
	assign wb_res_o   = w_res;

endmodule

// File: test/thor_core_asserts.sv
// Thor core assertions
// Reset and writeback strobe properties bound into the core

module thor_core_asserts
	import thor_pkg::*;
(
	input logic        clk_g,
	input logic        rst_i,
	input logic        d_valid,
	input thor_deco_t  d_deco,
	input logic        wb_valid_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failure count read by the testbench
	int fail_cnt = 0;

	// Quiet while in reset and for the cycle after
	a_reset_quiet: assert property (@(posedge clk_g)
		rst_i |-> ##1 !wb_valid_o ##1 !wb_valid_o)
		else begin
			fail_cnt++;
			$error("writeback strobe during or right after reset");
		end

	// Two edges from decode to the writeback strobe
	a_wb_follows: assert property (@(posedge clk_g) disable iff (rst_i)
		d_valid && d_deco.rfwr |-> ##2 wb_valid_o)
		else begin
			fail_cnt++;
			$error("no writeback strobe two edges after a writing instruction");
		end

endmodule

bind thor_core thor_core_asserts u_asserts (
	.clk_g      (clk_g),
	.rst_i      (rst_i),
	.d_valid    (d_valid),
	.d_deco     (d_deco),
	.wb_valid_o (wb_valid_o)
);

// File: test/thor_core_tb.sv
// Thor core testbench
// Directed tests of the integer pipeline against a register-level model
// with writeback strobes matched in order and at a fixed latency

module thor_core_tb
	import thor_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 4;
	localparam logic [31:0] SEED = 32'h2d5f_2931;
	// Upper bounds of each test in cycles
	localparam int LEN_RESET = 16;
	localparam int LEN_IMM = 120;
	localparam int LEN_REG = 500;
	localparam int LEN_BYPASS = 400;
	localparam int LEN_ZERO = 60;
	localparam int WATCHDOG_NS =
		(LEN_RESET + LEN_IMM + LEN_REG + LEN_BYPASS + LEN_ZERO) * CLK_PERIOD + 100;

	typedef struct {
		int          cyc;
		thor_regno_t rt;
		thor_value_t res;
	} wb_exp_t;

	logic        clk_g;
	logic        rst_i;
	logic        insn_valid_i;
	thor_insn_t  insn_i;
	logic        wb_valid_o;
	thor_regno_t wb_rt_o;
	thor_value_t wb_res_o;

	thor_value_t model_regs [64];
	wb_exp_t     exp_q [$];
	logic [31:0] lfsr;
	int          neg_cnt = 0;
	logic        mon_on = 1'b0;

	thor_core dut0 (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.insn_valid_i (insn_valid_i),
		.insn_i       (insn_i),
		.wb_valid_o   (wb_valid_o),
		.wb_rt_o      (wb_rt_o),
		.wb_res_o     (wb_res_o)
	);

	initial begin
		clk_g = 1'b0;
		forever #(CLK_PERIOD / 2) clk_g = ~clk_g;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(input string name, input thor_value_t got, input thor_value_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic thor_value_t lfsr_take(input int nbits);
		thor_value_t v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	// ========================================================================
	// Reference model
	// ========================================================================
	// Flipping the sign bit lets an unsigned compare order signed values
	function automatic thor_value_t cmp3(input thor_value_t a, input thor_value_t b,
		input logic sgn);
		thor_value_t ka;
		thor_value_t kb;
		ka = {a[63] ^ sgn, a[62:0]};
		kb = {b[63] ^ sgn, b[62:0]};
		if (ka < kb)
			return {64{1'b1}};
		if (ka == kb)
			return 64'd0;
		return 64'd1;
	endfunction

	// Returns 0 for an instruction that writes nothing
	function automatic logic model_exec(input thor_insn_t w, input thor_value_t a,
		input thor_value_t b, output thor_value_t res);
		thor_value_t imm;
		logic [5:0]  sh;
		imm = {{51{w[31]}}, w[31:19]};
		sh = b[5:0];
		res = '0;
		case (w[6:0])
			OP_R2: begin
				case (w[31:25])
					F_ADD:   res = a + b;
					F_SUB:   res = a - b;
					F_AND:   res = a & b;
					F_OR:    res = a | b;
					F_XOR:   res = a ^ b;
					F_SLL:   res = a << sh;
					F_SRL:   res = a >> sh;
					F_SRA:   res = (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'd0);
					F_CMP:   res = cmp3(a, b, 1'b1);
					F_CMPU:  res = cmp3(a, b, 1'b0);
					default: return 1'b0;
				endcase
			end
			OP_ADDI:  res = a + imm;
			OP_SUBFI: res = imm - a;
			OP_ANDI:  res = a & imm;
			OP_ORI:   res = a | imm;
			OP_XORI:  res = a ^ imm;
			OP_CMPI:  res = cmp3(a, imm, 1'b1);
			OP_CMPUI: res = cmp3(a, imm, 1'b0);
			OP_SLTI:  res = (cmp3(a, imm, 1'b1) == {64{1'b1}}) ? 64'd1 : 64'd0;
			OP_SLTUI: res = (cmp3(a, imm, 1'b0) == {64{1'b1}}) ? 64'd1 : 64'd0;
			OP_SEQI:  res = (a == imm) ? 64'd1 : 64'd0;
			default:  return 1'b0;
		endcase
		return 1'b1;
	endfunction

	function automatic thor_insn_t r2_word(input logic [6:0] fn, input thor_regno_t rt,
		input thor_regno_t ra, input thor_regno_t rb);
		return {fn, rb, ra, rt, OP_R2};
	endfunction

	function automatic thor_insn_t imm_word(input logic [6:0] op, input thor_regno_t rt,
		input thor_regno_t ra, input logic [12:0] imm);
		return {imm, ra, rt, op};
	endfunction

	// ========================================================================
	// Stimulus
	// ========================================================================
	// Strobe seen at the negedge after the third edge following this one
	task automatic issue(input thor_insn_t w);
		thor_value_t res;
		logic        wr;
		wb_exp_t     e;
		@(posedge clk_g);
		insn_valid_i <= 1'b1;
		insn_i <= w;
		wr = model_exec(w, model_regs[w[18:13]], model_regs[w[24:19]], res);
		if (wr && w[12:7] != '0) begin
			model_regs[w[12:7]] = res;
			e.cyc = neg_cnt + 4;
			e.rt = w[12:7];
			e.res = res;
			exp_q.push_back(e);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk_g);
			insn_valid_i <= 1'b0;
		end
	endtask

	task automatic drain();
		idle(6);
		check("pending writebacks", exp_q.size(), 0);
	endtask

	// Builds a 64-bit value from 4 + 5 x 12 bits using r63 as the shift of 12
	task automatic load_value(input thor_regno_t rt, input thor_value_t v);
		issue(imm_word(OP_ADDI, 6'd63, 6'd0, 13'd12));
		issue(imm_word(OP_ADDI, rt, 6'd0, {9'd0, v[63:60]}));
		for (int i = 4; i >= 0; i--) begin
			issue(r2_word(F_SLL, rt, rt, 6'd63));
			issue(imm_word(OP_ORI, rt, rt, {1'b0, v[i*12 +: 12]}));
		end
	endtask

	// Writeback monitor sampled on the falling edge away from the driving edge
	always @(negedge clk_g) begin : monitor
		wb_exp_t e;
		neg_cnt = neg_cnt + 1;
		if (dut0.u_asserts.fail_cnt != 0)
			fail_run("a core assertion failed");
		if (mon_on) begin
			if (wb_valid_o === 1'b1) begin
				if (exp_q.size() == 0) begin
					fail_run("writeback strobe with no instruction pending");
				end else begin
					e = exp_q.pop_front();
					check("strobe cycle", neg_cnt, e.cyc);
					check("wb_rt_o", wb_rt_o, e.rt);
					check("wb_res_o", wb_res_o, e.res);
				end
			end else if (wb_valid_o !== 1'b0) begin
				fail_run("writeback strobe is unknown after reset");
			end
			if (exp_q.size() != 0 && exp_q[0].cyc < neg_cnt)
				fail_run("expected writeback strobe did not come");
		end
	end

	// ========================================================================
	// Tests
	// ========================================================================
	task automatic reset_phase();
		for (int i = 0; i < RST_CYCLES; i++) begin
			@(posedge clk_g);
			if (i == RST_CYCLES - 1)
				rst_i <= 1'b0;
			@(negedge clk_g);
			check("wb_valid_o", wb_valid_o, 0);
		end
		mon_on = 1'b1;
		idle(4);
	endtask

	task automatic imm_ops();
		issue(imm_word(OP_ADDI, 6'd2, 6'd0, 13'h0123));
		issue(imm_word(OP_ADDI, 6'd3, 6'd0, 13'h1ffb));
		issue(imm_word(OP_ADDI, 6'd4, 6'd0, 13'h0fff));
		issue(imm_word(OP_ADDI, 6'd5, 6'd0, 13'h1000));
		idle(3);
		issue(imm_word(OP_ANDI, 6'd6, 6'd3, 13'h00f0));
		issue(imm_word(OP_ORI, 6'd7, 6'd2, 13'h1f00));
		issue(imm_word(OP_XORI, 6'd8, 6'd4, 13'h0aaa));
		issue(imm_word(OP_SUBFI, 6'd9, 6'd5, 13'h0064));
		issue(imm_word(OP_SLTI, 6'd10, 6'd3, 13'h1ffc));
		issue(imm_word(OP_SLTI, 6'd11, 6'd2, 13'h0005));
		issue(imm_word(OP_SLTUI, 6'd12, 6'd3, 13'h0007));
		issue(imm_word(OP_SLTUI, 6'd13, 6'd2, 13'h0fff));
		issue(imm_word(OP_SEQI, 6'd14, 6'd3, 13'h1ffb));
		issue(imm_word(OP_SEQI, 6'd15, 6'd2, 13'h0000));
		issue(imm_word(OP_CMPI, 6'd16, 6'd3, 13'h0003));
		issue(imm_word(OP_CMPI, 6'd17, 6'd2, 13'h0123));
		issue(imm_word(OP_CMPI, 6'd18, 6'd2, 13'h1fff));
		issue(imm_word(OP_CMPUI, 6'd19, 6'd3, 13'h0003));
		issue(imm_word(OP_CMPUI, 6'd20, 6'd2, 13'h0fff));
		drain();
	endtask

	task automatic reg_ops();
		thor_func_e fns [10] = '{F_ADD, F_SUB, F_AND, F_OR, F_XOR,
			F_SLL, F_SRL, F_SRA, F_CMP, F_CMPU};
		for (int r = 0; r < 6; r++) begin
			load_value(6'd20, lfsr_take(64));
			// Equal operands in the first round
			load_value(6'd21, r == 0 ? model_regs[20] : lfsr_take(64));
			for (int i = 0; i < 10; i++)
				issue(r2_word(fns[i], thor_regno_t'(22 + i), 6'd20, 6'd21));
			issue(imm_word(OP_ADDI, 6'd34, 6'd0, 13'd63));
			issue(r2_word(F_SRA, 6'd35, 6'd20, 6'd34));
			issue(r2_word(F_SLL, 6'd36, 6'd21, 6'd34));
			drain();
		end
	endtask

	task automatic bypass_chains();
		thor_func_e chain [8] = '{F_ADD, F_XOR, F_SUB, F_OR, F_SRL, F_AND, F_CMPU, F_ADD};
		for (int gap = 0; gap < 4; gap++) begin
			load_value(6'd40, lfsr_take(64));
			idle(4);
			for (int i = 0; i < 8; i++) begin
				// Ra is the previous result and Rb the one before it
				issue(r2_word(chain[i], thor_regno_t'(41 + i), thor_regno_t'(40 + i),
					thor_regno_t'(i == 0 ? 40 : 39 + i)));
				idle(gap);
			end
			drain();
		end
	endtask

	task automatic zero_and_unknown();
		issue(imm_word(OP_ADDI, 6'd0, 6'd2, 13'h0037));
		issue(r2_word(F_ADD, 6'd52, 6'd0, 6'd2));
		issue(r2_word(F_ADD, 6'd0, 6'd2, 6'd2));
		issue(r2_word(F_OR, 6'd53, 6'd0, 6'd0));
		issue(imm_word(7'h7f, 6'd50, 6'd2, 13'h0001));
		issue(r2_word(7'h7e, 6'd51, 6'd2, 6'd2));
		issue(imm_word(7'h00, 6'd54, 6'd3, 13'h0005));
		idle(3);
		issue(imm_word(OP_ORI, 6'd55, 6'd0, 13'h0000));
		issue(r2_word(F_ADD, 6'd56, 6'd0, 6'd0));
		drain();
	endtask

	initial begin
		lfsr = SEED;
		model_regs[0] = '0;
		rst_i = 1'b1;
		insn_valid_i = 1'b0;
		insn_i = '0;
		reset_phase();
		imm_ops();
		reg_ops();
		bypass_chains();
		zero_and_unknown();
		if (exp_q.size() == 0 && dut0.u_asserts.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			fail_run("assertion failures or writebacks left pending");
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		fail_run("watchdog timeout, tests did not finish");
	end

endmodule

// File: thor_core.f
+incdir+include
logic/thor_pkg.sv
logic/thor_fwd_if.sv
logic/thor_decoder.sv
logic/thor_regfile.sv
logic/thor_alu.sv
logic/thor_core.sv
test/thor_core_asserts.sv
test/thor_core_tb.sv

// File: Bender.yml
package:
  name: thor_core

export_include_dirs:
  - include

sources:
  - logic/thor_pkg.sv
  - logic/thor_fwd_if.sv
  - logic/thor_decoder.sv
  - logic/thor_regfile.sv
  - logic/thor_alu.sv
  - logic/thor_core.sv
  - target: test
    files:
      - test/thor_core_asserts.sv
      - test/thor_core_tb.sv
